// ==== design/pcr_cpu_if.sv ====
module pcr_cpu_if (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                cpu_req_valid_i,
    output logic                                cpu_req_ready_o,
    input  pcr_regmap_pkg::cpu_req_t            cpu_req_i,
    output logic                                cpu_rsp_valid_o,
    input  logic                                cpu_rsp_ready_i,
    output pcr_regmap_pkg::cpu_rsp_t            cpu_rsp_o,
    output logic                                ctrl_wr_o,
    output pcr_vault_pkg::pcr_entry_idx_t       ctrl_entry_o,
    output logic                                ctrl_lock_o,
    output logic                                ctrl_clear_o,
    input  logic [pcr_vault_pkg::NUM_PCR-1:0]   lock_i,
    output pcr_vault_pkg::pcr_entry_idx_t       rd_entry_o,
    output pcr_vault_pkg::pcr_dword_idx_t       rd_dword_o,
    input  pcr_vault_pkg::pcr_data_t            rd_data_i
);

    pcr_regmap_pkg::pcr_addr_t entry_off;
    pcr_regmap_pkg::pcr_addr_t ctrl_off;
    logic                      is_entry;
    logic                      is_ctrl;
    logic                      dec_error;
    logic                      req_fire;
    logic                      rsp_valid_q;
    pcr_regmap_pkg::cpu_rsp_t  rsp_q;
    pcr_regmap_pkg::cpu_rsp_t  rsp_next;

    // single outstanding request, new one only once the response is gone
    assign cpu_req_ready_o = ~rsp_valid_q;
    assign req_fire        = cpu_req_valid_i & cpu_req_ready_o;

    // region decode
    assign entry_off = cpu_req_i.addr - pcr_regmap_pkg::ENTRY_BASE;
    assign ctrl_off  = cpu_req_i.addr - pcr_regmap_pkg::CTRL_BASE;
    assign is_entry  = cpu_req_i.addr < pcr_regmap_pkg::CTRL_BASE;
    assign is_ctrl   = ~is_entry & (cpu_req_i.addr < pcr_regmap_pkg::MAP_END);

    // misaligned, out of map, or a write into entry storage
    assign dec_error = (cpu_req_i.addr[1:0] != 2'b00) | ~(is_entry | is_ctrl)
                     | (is_entry & cpu_req_i.write);

    // store read port follows the request address
    assign rd_entry_o = entry_off[5:4];
    assign rd_dword_o = entry_off[3:2];

    // control writes go out as a strobe in the accept cycle
    assign ctrl_wr_o    = req_fire & is_ctrl & cpu_req_i.write & ~dec_error;
    assign ctrl_entry_o = ctrl_off[3:2];
    assign ctrl_lock_o  = cpu_req_i.wdata[pcr_regmap_pkg::CTRL_LOCK_BIT];
    assign ctrl_clear_o = cpu_req_i.wdata[pcr_regmap_pkg::CTRL_CLEAR_BIT];

    always_comb begin
        rsp_next       = '0;
        rsp_next.error = dec_error;
        if (!dec_error && !cpu_req_i.write) begin
            if (is_entry) begin
                rsp_next.rdata = rd_data_i;
            end else begin
                rsp_next.rdata[pcr_regmap_pkg::CTRL_LOCK_BIT] = lock_i[ctrl_entry_o];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (cpu_rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // response payload, held until taken
    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_q <= rsp_next;
        end
    end

    assign cpu_rsp_valid_o = rsp_valid_q;
    assign cpu_rsp_o       = rsp_q;

endmodule

// ==== design/pcr_ctrl_regs.sv ====
module pcr_ctrl_regs (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                pwrgood_i,
    input  logic                                ctrl_wr_i,
    input  pcr_vault_pkg::pcr_entry_idx_t       ctrl_entry_i,
    input  logic                                ctrl_lock_i,
    input  logic                                ctrl_clear_i,
    output logic [pcr_vault_pkg::NUM_PCR-1:0]   lock_o,
    output logic [pcr_vault_pkg::NUM_PCR-1:0]   clear_o
);

    logic [pcr_vault_pkg::NUM_PCR-1:0] entry_wr;
    logic [pcr_vault_pkg::NUM_PCR-1:0] lock_set;
    logic [pcr_vault_pkg::NUM_PCR-1:0] clear_next;
    logic [pcr_vault_pkg::NUM_PCR-1:0] lock_q;
    logic [pcr_vault_pkg::NUM_PCR-1:0] clear_q;

    // per-entry write enable, blocked while that entry is locked
    always_comb begin
        for (int e = 0; e < pcr_vault_pkg::NUM_PCR; e++) begin
            entry_wr[e]   = ctrl_wr_i
                          & (ctrl_entry_i == pcr_vault_pkg::pcr_entry_idx_t'(e))
                          & ~lock_q[e];
            lock_set[e]   = entry_wr[e] & ctrl_lock_i;
            clear_next[e] = entry_wr[e] & ctrl_clear_i;
        end
    end

    // sticky lock, only power-good releases it
    always_ff @(posedge clk or negedge pwrgood_i) begin
        if (!pwrgood_i) begin
            lock_q <= '0;
        end else begin
            lock_q <= lock_q | lock_set;
        end
    end

    // clear pulse lasts one cycle since it is recomputed every cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            clear_q <= '0;
        end else begin
            clear_q <= clear_next;
        end
    end

    assign lock_o  = lock_q;
    assign clear_o = clear_q;

endmodule

// ==== design/pcr_regmap_pkg.sv ====
package pcr_regmap_pkg;

    localparam int ADDR_W = 8;

    typedef logic [ADDR_W-1:0] pcr_addr_t;

    // entry region, dword address is entry*16 + dword*4
    localparam pcr_addr_t ENTRY_BASE = 8'h00;
    // control region, one word per entry at entry*4
    localparam pcr_addr_t CTRL_BASE  = 8'h40;
    localparam pcr_addr_t MAP_END    = 8'h50;

    // control word fields
    localparam int CTRL_LOCK_BIT  = 0;
    localparam int CTRL_CLEAR_BIT = 1;

    typedef struct packed {
        logic                     write;
        pcr_addr_t                addr;
        pcr_vault_pkg::pcr_data_t wdata;
    } cpu_req_t;

    typedef struct packed {
        pcr_vault_pkg::pcr_data_t rdata;
        logic                     error;
    } cpu_rsp_t;

endpackage

// ==== design/pcr_store.sv ====
module pcr_store (
    input  logic                                clk,
    input  logic                                pwrgood_i,
    input  logic [pcr_vault_pkg::NUM_PCR-1:0]   clear_i,
    input  pcr_vault_pkg::pcr_write_t [pcr_vault_pkg::NUM_WRITE-1:0]   pcr_write_i,
    input  pcr_vault_pkg::pcr_read_t [pcr_vault_pkg::NUM_READ-1:0]     pcr_read_i,
    output pcr_vault_pkg::pcr_rd_resp_t [pcr_vault_pkg::NUM_READ-1:0]  pcr_rd_resp_o,
    input  pcr_vault_pkg::pcr_entry_idx_t       rd_entry_i,
    input  pcr_vault_pkg::pcr_dword_idx_t       rd_dword_i,
    output pcr_vault_pkg::pcr_data_t            rd_data_o
);

    localparam int NP = pcr_vault_pkg::NUM_PCR;
    localparam int ND = pcr_vault_pkg::NUM_DWORDS;

    pcr_vault_pkg::pcr_data_t data_q    [NP][ND];
    pcr_vault_pkg::pcr_data_t wr_data   [NP][ND];
    logic                     wr_en     [NP][ND];

    // AND-OR merge of all write clients per dword
    // colliding writes to one dword land as the OR of their data
    always_comb begin
        for (int e = 0; e < NP; e++) begin
            for (int d = 0; d < ND; d++) begin
                logic hit;
                wr_en[e][d]   = 1'b0;
                wr_data[e][d] = '0;
                for (int c = 0; c < pcr_vault_pkg::NUM_WRITE; c++) begin
                    hit = pcr_write_i[c].write_en
                        & (pcr_write_i[c].write_entry == pcr_vault_pkg::pcr_entry_idx_t'(e))
                        & (pcr_write_i[c].write_offset == pcr_vault_pkg::pcr_dword_idx_t'(d));
                    wr_en[e][d]   = wr_en[e][d] | hit;
                    wr_data[e][d] = wr_data[e][d] | (hit ? pcr_write_i[c].write_data : '0);
                end
            end
        end
    end

    // entry storage, clear wins over a client write in the same cycle
    always_ff @(posedge clk or negedge pwrgood_i) begin
        if (!pwrgood_i) begin
            for (int e = 0; e < NP; e++) begin
                for (int d = 0; d < ND; d++) begin
                    data_q[e][d] <= '0;
                end
            end
        end else begin
            for (int e = 0; e < NP; e++) begin
                for (int d = 0; d < ND; d++) begin
                    if (clear_i[e]) begin
                        data_q[e][d] <= '0;
                    end else if (wr_en[e][d]) begin
                        data_q[e][d] <= wr_data[e][d];
                    end
                end
            end
        end
    end

    // client read ports, qualified on entry and offset
    always_comb begin
        for (int c = 0; c < pcr_vault_pkg::NUM_READ; c++) begin
            pcr_rd_resp_o[c].read_data = '0;
            for (int e = 0; e < NP; e++) begin
                for (int d = 0; d < ND; d++) begin
                    if (pcr_read_i[c].read_entry == pcr_vault_pkg::pcr_entry_idx_t'(e) &&
                        pcr_read_i[c].read_offset == pcr_vault_pkg::pcr_dword_idx_t'(d)) begin
                        pcr_rd_resp_o[c].read_data = pcr_rd_resp_o[c].read_data
                                                   | data_q[e][d];
                    end
                end
            end
            pcr_rd_resp_o[c].last = pcr_read_i[c].read_offset
                                  == pcr_vault_pkg::pcr_dword_idx_t'(ND - 1);
        end
    end

    // firmware read port
    assign rd_data_o = data_q[rd_entry_i][rd_dword_i];

endmodule

// ==== design/pcr_vault_pkg.sv ====
package pcr_vault_pkg;

    // vault geometry
    localparam int NUM_PCR    = 4;
    localparam int NUM_DWORDS = 4;

    // hardware client counts
    localparam int NUM_WRITE = 2;
    localparam int NUM_READ  = 2;

    localparam int DATA_W      = 32;
    localparam int ENTRY_IDX_W = $clog2(NUM_PCR);
    localparam int DWORD_IDX_W = $clog2(NUM_DWORDS);

    typedef logic [DATA_W-1:0]      pcr_data_t;
    typedef logic [ENTRY_IDX_W-1:0] pcr_entry_idx_t;
    typedef logic [DWORD_IDX_W-1:0] pcr_dword_idx_t;

    // one dword write from a crypto client
    typedef struct packed {
        logic           write_en;
        pcr_entry_idx_t write_entry;
        pcr_dword_idx_t write_offset;
        pcr_data_t      write_data;
    } pcr_write_t;

    // read address from a crypto client
    typedef struct packed {
        pcr_entry_idx_t read_entry;
        pcr_dword_idx_t read_offset;
    } pcr_read_t;

    // read response, last flags the final dword of an entry
    typedef struct packed {
        pcr_data_t read_data;
        logic      last;
    } pcr_rd_resp_t;

endpackage

// ==== design/pcr_vault_top.sv ====
module pcr_vault_top (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                pwrgood_i,

    // firmware request/response port
    input  logic                                cpu_req_valid_i,
    output logic                                cpu_req_ready_o,
    input  pcr_regmap_pkg::cpu_req_t            cpu_req_i,
    output logic                                cpu_rsp_valid_o,
    input  logic                                cpu_rsp_ready_i,
    output pcr_regmap_pkg::cpu_rsp_t            cpu_rsp_o,

    // crypto client ports
    input  pcr_vault_pkg::pcr_write_t [pcr_vault_pkg::NUM_WRITE-1:0]   pcr_write_i,
    input  pcr_vault_pkg::pcr_read_t [pcr_vault_pkg::NUM_READ-1:0]     pcr_read_i,
    output pcr_vault_pkg::pcr_rd_resp_t [pcr_vault_pkg::NUM_READ-1:0]  pcr_rd_resp_o
);

    logic                              ctrl_wr;
    pcr_vault_pkg::pcr_entry_idx_t     ctrl_entry;
    logic                              ctrl_lock;
    logic                              ctrl_clear;
    logic [pcr_vault_pkg::NUM_PCR-1:0] lock;
    logic [pcr_vault_pkg::NUM_PCR-1:0] clear;
    pcr_vault_pkg::pcr_entry_idx_t     rd_entry;
    pcr_vault_pkg::pcr_dword_idx_t     rd_dword;
    pcr_vault_pkg::pcr_data_t          rd_data;

    pcr_cpu_if u_cpu_if (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .cpu_req_valid_i (cpu_req_valid_i),
        .cpu_req_ready_o (cpu_req_ready_o),
        .cpu_req_i       (cpu_req_i),
        .cpu_rsp_valid_o (cpu_rsp_valid_o),
        .cpu_rsp_ready_i (cpu_rsp_ready_i),
        .cpu_rsp_o       (cpu_rsp_o),
        .ctrl_wr_o       (ctrl_wr),
        .ctrl_entry_o    (ctrl_entry),
        .ctrl_lock_o     (ctrl_lock),
        .ctrl_clear_o    (ctrl_clear),
        .lock_i          (lock),
        .rd_entry_o      (rd_entry),
        .rd_dword_o      (rd_dword),
        .rd_data_i       (rd_data)
    );

    // locks sit on the power-good domain
    pcr_ctrl_regs u_ctrl (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pwrgood_i    (pwrgood_i),
        .ctrl_wr_i    (ctrl_wr),
        .ctrl_entry_i (ctrl_entry),
        .ctrl_lock_i  (ctrl_lock),
        .ctrl_clear_i (ctrl_clear),
        .lock_o       (lock),
        .clear_o      (clear)
    );

    pcr_store u_store (
        .clk           (clk),
        .pwrgood_i     (pwrgood_i),
        .clear_i       (clear),
        .pcr_write_i   (pcr_write_i),
        .pcr_read_i    (pcr_read_i),
        .pcr_rd_resp_o (pcr_rd_resp_o),
        .rd_entry_i    (rd_entry),
        .rd_dword_i    (rd_dword),
        .rd_data_o     (rd_data)
    );

endmodule

// ==== pcr_vault_top.f ====
+incdir+tb
design/pcr_vault_pkg.sv
design/pcr_regmap_pkg.sv
design/pcr_cpu_if.sv
design/pcr_ctrl_regs.sv
design/pcr_store.sv
design/pcr_vault_top.sv
tb/pcr_vault_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module pcr_vault_tb \
    -f pcr_vault_top.f \
    -o pcr_vault_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/pcr_vault_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

// ==== tb/pcr_vault_model.svh ====
`ifndef PCR_VAULT_MODEL_SVH
`define PCR_VAULT_MODEL_SVH

// reference state, advanced once per rising edge
pcr_vault_pkg::pcr_data_t m_ent [pcr_vault_pkg::NUM_PCR][pcr_vault_pkg::NUM_DWORDS];
logic [pcr_vault_pkg::NUM_PCR-1:0] m_lock;
logic [pcr_vault_pkg::NUM_PCR-1:0] m_clr;
logic                              m_held;
logic                              m_accepted;
pcr_regmap_pkg::cpu_rsp_t          m_rsp_q [$];

// 0 entry dword, 1 control word, 2 decode error
function automatic int addr_kind(pcr_regmap_pkg::pcr_addr_t a);
    if (a[1:0] != 2'b00 || a >= pcr_regmap_pkg::MAP_END) begin
        return 2;
    end
    return (a < pcr_regmap_pkg::CTRL_BASE) ? 0 : 1;
endfunction

function automatic pcr_regmap_pkg::cpu_rsp_t expected_rsp(pcr_regmap_pkg::cpu_req_t req);
    pcr_regmap_pkg::cpu_rsp_t rsp;
    int kind;
    kind = addr_kind(req.addr);
    rsp  = '0;
    if (kind == 2 || (kind == 0 && req.write)) begin
        rsp.error = 1'b1;
    end else if (!req.write && kind == 0) begin
        rsp.rdata = m_ent[req.addr[5:4]][req.addr[3:2]];
    end else if (!req.write) begin
        rsp.rdata = {31'b0, m_lock[req.addr[3:2]]};
    end
    return rsp;
endfunction

task automatic model_edge();
    logic [pcr_vault_pkg::NUM_PCR-1:0] clr_now;
    logic                              hit;
    pcr_vault_pkg::pcr_data_t          val;
    pcr_vault_pkg::pcr_entry_idx_t     e;
    // the clear pulse register sits in the arst domain
    clr_now    = arst_n ? m_clr : '0;
    m_clr      = '0;
    m_accepted = 1'b0;
    if (!arst_n) begin
        m_held = 1'b0;
        m_rsp_q.delete();
    end else if (m_held) begin
        if (cpu_rsp_ready) begin
            m_held = 1'b0;
            m_rsp_q.delete();
        end
    end else if (cpu_req_valid) begin
        m_rsp_q.push_back(expected_rsp(cpu_req));
        m_held     = 1'b1;
        m_accepted = 1'b1;
        e          = cpu_req.addr[3:2];
        if (addr_kind(cpu_req.addr) == 1 && cpu_req.write && !m_lock[e]) begin
            m_lock[e] = m_lock[e] | cpu_req.wdata[pcr_regmap_pkg::CTRL_LOCK_BIT];
            m_clr[e]  = cpu_req.wdata[pcr_regmap_pkg::CTRL_CLEAR_BIT];
        end
    end
    for (int i = 0; i < pcr_vault_pkg::NUM_PCR; i++) begin
        for (int d = 0; d < pcr_vault_pkg::NUM_DWORDS; d++) begin
            hit = 1'b0;
            val = '0;
            for (int c = 0; c < pcr_vault_pkg::NUM_WRITE; c++) begin
                if (pcr_write[c].write_en && int'(pcr_write[c].write_entry) == i &&
                    int'(pcr_write[c].write_offset) == d) begin
                    hit = 1'b1;
                    val = val | pcr_write[c].write_data;
                end
            end
            if (clr_now[i] || !pwrgood) begin
                m_ent[i][d] = '0;
            end else if (hit) begin
                m_ent[i][d] = val;
            end
        end
    end
    if (!pwrgood) begin
        m_lock = '0;
    end
endtask

`endif

// ==== tb/pcr_vault_tb.sv ====
module pcr_vault_tb;

    localparam int RAND_CYCLES = 1000;
    // limit of ten times the two random phases that dominate the run
    localparam int MAX_CYCLES  = 10 * (2 * RAND_CYCLES);

    logic                                                        clk;
    logic                                                        arst_n;
    logic                                                        pwrgood;
    logic                                                        cpu_req_valid;
    logic                                                        cpu_req_ready;
    pcr_regmap_pkg::cpu_req_t                                    cpu_req;
    logic                                                        cpu_rsp_valid;
    logic                                                        cpu_rsp_ready;
    pcr_regmap_pkg::cpu_rsp_t                                    cpu_rsp;
    pcr_vault_pkg::pcr_write_t [pcr_vault_pkg::NUM_WRITE-1:0]    pcr_write;
    pcr_vault_pkg::pcr_read_t [pcr_vault_pkg::NUM_READ-1:0]      pcr_read;
    pcr_vault_pkg::pcr_rd_resp_t [pcr_vault_pkg::NUM_READ-1:0]   pcr_rd_resp;

    int   seed;
    int   cycles;

    `include "pcr_vault_model.svh"

    pcr_vault_top dut_i (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .pwrgood_i       (pwrgood),
        .cpu_req_valid_i (cpu_req_valid),
        .cpu_req_ready_o (cpu_req_ready),
        .cpu_req_i       (cpu_req),
        .cpu_rsp_valid_o (cpu_rsp_valid),
        .cpu_rsp_ready_i (cpu_rsp_ready),
        .cpu_rsp_o       (cpu_rsp),
        .pcr_write_i     (pcr_write),
        .pcr_read_i      (pcr_read),
        .pcr_rd_resp_o   (pcr_rd_resp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        model_edge();
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the test sequence did not complete in %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // outputs are stable at the falling edge before new inputs go out
    task automatic next_cycle();
        pcr_vault_pkg::pcr_read_t rd;
        @(negedge clk);
        check_value("cpu_rsp_valid_o", 32'(cpu_rsp_valid), 32'(m_held));
        check_value("cpu_req_ready_o", 32'(cpu_req_ready), 32'(!m_held));
        if (m_held) begin
            check_value("cpu_rsp_o.rdata", cpu_rsp.rdata, m_rsp_q[0].rdata);
            check_value("cpu_rsp_o.error", 32'(cpu_rsp.error), 32'(m_rsp_q[0].error));
        end
        for (int c = 0; c < pcr_vault_pkg::NUM_READ; c++) begin
            rd = pcr_read[c];
            check_value($sformatf("pcr_rd_resp_o[%0d].read_data", c),
                        pcr_rd_resp[c].read_data, m_ent[rd.read_entry][rd.read_offset]);
            check_value($sformatf("pcr_rd_resp_o[%0d].last", c), 32'(pcr_rd_resp[c].last),
                        32'(int'(rd.read_offset) == pcr_vault_pkg::NUM_DWORDS - 1));
        end
    endtask

    function automatic pcr_regmap_pkg::cpu_req_t random_request();
        pcr_regmap_pkg::cpu_req_t req;
        int r;
        r         = $random(seed);
        req.write = r[0];
        req.wdata = $random(seed);
        case (r[3:1])
            3'd0, 3'd1, 3'd2: req.addr = {2'b00, r[9:8], r[11:10], 2'b00};
            // control words with the lock bit set only now and then
            3'd3, 3'd4: begin
                req.addr     = pcr_regmap_pkg::CTRL_BASE | {4'b0, r[9:8], 2'b00};
                req.wdata[0] = (r[16:12] == 5'd0);
            end
            3'd5: req.addr = {1'b0, r[14:8]};
            default: req.addr = r[23:16];
        endcase
        return req;
    endfunction

    task automatic random_cycle();
        int r;
        next_cycle();
        for (int c = 0; c < pcr_vault_pkg::NUM_WRITE; c++) begin
            r = $random(seed);
            pcr_write[c].write_en     = r[0];
            pcr_write[c].write_entry  = r[5:4];
            pcr_write[c].write_offset = r[7:6];
            pcr_write[c].write_data   = $random(seed);
        end
        r = $random(seed);
        // force a collision on one dword every few cycles
        if (r[1:0] == 2'b00) begin
            pcr_write[1].write_en     = 1'b1;
            pcr_write[1].write_entry  = pcr_write[0].write_entry;
            pcr_write[1].write_offset = pcr_write[0].write_offset;
        end
        pcr_read[0]   = r[11:8];
        pcr_read[1]   = r[15:12];
        cpu_rsp_ready = (r[3:2] != 2'b00);
        if (!cpu_req_valid || m_accepted) begin
            cpu_req_valid = r[4];
            cpu_req       = random_request();
        end
    endtask

    task automatic quiet();
        pcr_write     = '0;
        cpu_req_valid = 1'b0;
        cpu_rsp_ready = 1'b1;
    endtask

    // let a pending request finish and its response drain
    task automatic drain();
        pcr_write     = '0;
        cpu_rsp_ready = 1'b1;
        while (cpu_req_valid) begin
            next_cycle();
            if (m_accepted) begin
                cpu_req_valid = 1'b0;
            end
        end
        next_cycle();
        while (cpu_rsp_valid) begin
            next_cycle();
        end
    endtask

    // returns at the falling edge where the response first shows
    task automatic cpu_op(input logic wr, input pcr_regmap_pkg::pcr_addr_t addr,
                          input pcr_vault_pkg::pcr_data_t wdata,
                          output pcr_regmap_pkg::cpu_rsp_t rsp);
        cpu_req.write = wr;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_req_valid = 1'b1;
        cpu_rsp_ready = 1'b1;
        do begin
            next_cycle();
        end while (!cpu_rsp_valid);
        rsp           = cpu_rsp;
        cpu_req_valid = 1'b0;
    endtask

    task automatic client_write(input int c, input int entry, input int dword,
                                input pcr_vault_pkg::pcr_data_t data);
        pcr_write[c].write_en     = 1'b1;
        pcr_write[c].write_entry  = pcr_vault_pkg::pcr_entry_idx_t'(entry);
        pcr_write[c].write_offset = pcr_vault_pkg::pcr_dword_idx_t'(dword);
        pcr_write[c].write_data   = data;
    endtask

    task automatic pulse_reset(input logic power);
        quiet();
        if (power) begin
            pwrgood = 1'b0;
        end else begin
            arst_n = 1'b0;
        end
        next_cycle();
        next_cycle();
        pwrgood = 1'b1;
        arst_n  = 1'b1;
        next_cycle();
    endtask

    initial begin
        pcr_regmap_pkg::cpu_rsp_t rsp;
        seed      = 32'h5179_19f5;
        clk       = 1'b0;
        arst_n    = 1'b0;
        pwrgood   = 1'b0;
        cycles    = 0;
        cpu_req   = '0;
        pcr_read  = '0;
        quiet();
        repeat (3) @(negedge clk);
        arst_n    = 1'b1;
        pwrgood   = 1'b1;

        repeat (RAND_CYCLES) random_cycle();
        drain();

        // power-good alone releases every lock
        pulse_reset(1'b1);
        for (int e = 0; e < pcr_vault_pkg::NUM_PCR; e++) begin
            cpu_op(1'b0, pcr_regmap_pkg::CTRL_BASE + pcr_regmap_pkg::pcr_addr_t'(4 * e), '0, rsp);
            check_value("lock after pwrgood", rsp.rdata, 32'h0);
        end

        // clear of entry 1 while both clients write it in the pulse cycle
        client_write(0, 1, 2, 32'ha5a5_0001);
        client_write(1, 1, 0, 32'h5a5a_0002);
        next_cycle();
        quiet();
        cpu_op(1'b1, 8'h44, 32'h2, rsp);
        client_write(0, 1, 2, 32'h1111_1111);
        client_write(1, 1, 0, 32'h2222_2222);
        next_cycle();
        quiet();
        cpu_op(1'b0, 8'h18, '0, rsp);
        check_value("entry 1 dword 2 after clear", rsp.rdata, 32'h0);
        pcr_read[1] = {2'd1, 2'd0};
        next_cycle();
        check_value("client read entry 1 dword 0", pcr_rd_resp[1].read_data, 32'h0);

        // locked entry 2 ignores control writes but takes client writes
        client_write(0, 2, 3, 32'h1234_5678);
        next_cycle();
        quiet();
        cpu_op(1'b1, 8'h48, 32'h1, rsp);
        cpu_op(1'b1, 8'h48, 32'h2, rsp);
        cpu_op(1'b1, 8'h48, 32'h0, rsp);
        cpu_op(1'b0, 8'h48, '0, rsp);
        check_value("lock of entry 2", rsp.rdata, 32'h1);
        cpu_op(1'b0, 8'h2c, '0, rsp);
        check_value("entry 2 dword 3 under lock", rsp.rdata, 32'h1234_5678);
        client_write(1, 2, 1, 32'hcafe_0002);
        next_cycle();
        quiet();
        cpu_op(1'b0, 8'h24, '0, rsp);
        check_value("client write to locked entry", rsp.rdata, 32'hcafe_0002);

        // the ordinary reset keeps locks and data
        pulse_reset(1'b0);
        cpu_op(1'b0, 8'h48, '0, rsp);
        check_value("lock after arst", rsp.rdata, 32'h1);
        cpu_op(1'b0, 8'h2c, '0, rsp);
        check_value("entry 2 dword 3 after arst", rsp.rdata, 32'h1234_5678);

        pulse_reset(1'b1);
        cpu_op(1'b0, 8'h48, '0, rsp);
        check_value("lock after second pwrgood", rsp.rdata, 32'h0);
        pcr_read[0] = {2'd2, 2'd3};
        next_cycle();
        check_value("client read after pwrgood", pcr_rd_resp[0].read_data, 32'h0);

        repeat (RAND_CYCLES) random_cycle();
        drain();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
